// File: Makefile
TOP = nibble_uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f nibble_uart.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f nibble_uart.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q "Testbench failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/frame_builder.sv
`timescale 1ns/1ps

`include "nibble_uart_consts.svh"

module frame_builder (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  en,
    input  logic [`NU_NUM_DIGITS*`NU_DIGIT_W-1:0] digits,
    input  logic                                  full,
    output logic                                  push,
    output nibble_uart_pkg::frame_byte_u          push_byte
);

    import nibble_uart_pkg::*;

    localparam int CNT_W = $clog2(`NU_FRAME_PERIOD);
    localparam int IDX_W = $clog2(`NU_FRAME_BYTES);
    localparam logic [IDX_W-1:0] IDX_CHECK = IDX_W'(`NU_FRAME_BYTES - 1);

    logic [CNT_W-1:0]                        period_cnt;
    logic                                    tick;
    logic                                    start;
    logic                                    accept;
    logic                                    active;   // frame in progress.
    logic [IDX_W-1:0]                        byte_idx;
    logic [`NU_NUM_DIGITS*`NU_DIGIT_W-1:0]   digits_q; // snapshot at tick.
    frame_byte_u                             check_q;  // running xor.
    logic                                    is_payload;

    // pick digit k out of the snapshot.
    function automatic logic [`NU_DIGIT_W-1:0] digit_at(input int k);
        return digits_q[k*`NU_DIGIT_W +: `NU_DIGIT_W];
    endfunction

    ////////////////////////////////////////////////////////////
    // period tick and frame start.
    ////////////////////////////////////////////////////////////

    assign tick   = (period_cnt == CNT_W'(`NU_FRAME_PERIOD - 1));
    assign start  = tick && en && !active;   // late ticks dropped.
    assign push   = active;
    assign accept = push && !full;

    // bytes 2..5 carry digits.
    assign is_payload = (byte_idx > IDX_W'(1)) && (byte_idx < IDX_CHECK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
            active     <= 1'b0;
            byte_idx   <= '0;
            check_q    <= '0;
        end else begin
            period_cnt <= tick ? '0 : period_cnt + 1'b1; // free running.
            if (start) begin
                active   <= 1'b1;
                byte_idx <= '0;
                check_q  <= '0;
            end else if (accept) begin
                if (is_payload)
                    check_q.raw <= check_q.raw ^ push_byte.raw;
                if (byte_idx == IDX_CHECK)
                    active <= 1'b0;          // check byte taken.
                else
                    byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    // digits held for the whole frame.
    always_ff @(posedge clk) begin
        if (start)
            digits_q <= digits;
    end

    ////////////////////////////////////////////////////////////
    // byte select.
    ////////////////////////////////////////////////////////////

    always_comb begin
        push_byte.raw = '0;
        case (byte_idx)
            IDX_W'(0): push_byte.raw = `NU_SYNC0;
            IDX_W'(1): push_byte.raw = `NU_SYNC1;
            IDX_W'(2): begin
                push_byte.pair.hi = digit_at(7);
                push_byte.pair.lo = digit_at(6);
            end
            IDX_W'(3): begin
                push_byte.pair.hi = digit_at(5);
                push_byte.pair.lo = digit_at(4);
            end
            IDX_W'(4): begin
                push_byte.pair.hi = digit_at(3);
                push_byte.pair.lo = digit_at(2);
            end
            IDX_W'(5): begin
                push_byte.pair.hi = digit_at(1);
                push_byte.pair.lo = digit_at(0);
            end
            IDX_CHECK: push_byte.raw = check_q.raw;  // xor of payload.
            default:   push_byte.raw = '0;
        endcase
    end

endmodule

// File: hw/nibble_uart_consts.svh
`ifndef NIBBLE_UART_CONSTS_SVH
`define NIBBLE_UART_CONSTS_SVH

////////////////////////////////////////////////////////////
// frame layout.
////////////////////////////////////////////////////////////

`define NU_NUM_DIGITS   8        // digits per frame.
`define NU_DIGIT_W      4        // bits per digit.
`define NU_FRAME_BYTES  7        // sync x2, payload x4, check.

`define NU_SYNC0        8'h55    // first sync byte.
`define NU_SYNC1        8'hAA    // second sync byte.

////////////////////////////////////////////////////////////
// timing and buffering.
////////////////////////////////////////////////////////////

// short bit time for fast simulation.
`define NU_CLKS_PER_BIT 4

// cycles between ticks; must exceed 7 * 10 * NU_CLKS_PER_BIT.
`define NU_FRAME_PERIOD 400

`define NU_FIFO_DEPTH   8        // power of two.

`endif

// File: hw/nibble_uart_pkg.sv
package nibble_uart_pkg;

    `include "nibble_uart_consts.svh"

    ////////////////////////////////////////////////////////////
    // frame byte, seen as raw data or as two digits.
    ////////////////////////////////////////////////////////////

    // high digit sits in the upper nibble.
    typedef struct packed {
        logic [`NU_DIGIT_W-1:0] hi;  // odd digit of the pair.
        logic [`NU_DIGIT_W-1:0] lo;  // even digit of the pair.
    } digit_pair_t;

    // sync and check bytes use raw.
    // payload bytes use pair.
    typedef union packed {
        logic [2*`NU_DIGIT_W-1:0] raw;
        digit_pair_t              pair;
    } frame_byte_u;

endpackage

// File: hw/nibble_uart_top.sv
`timescale 1ns/1ps

`include "nibble_uart_consts.svh"

module nibble_uart_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  en,
    input  logic [`NU_NUM_DIGITS*`NU_DIGIT_W-1:0] digits,
    output logic                                  tx_pin,
    output logic                                  tx_busy
);

    import nibble_uart_pkg::*;

    ////////////////////////////////////////////////////////////
    // builder -> fifo -> uart.
    ////////////////////////////////////////////////////////////

    logic        push;       // builder strobe.
    frame_byte_u push_byte;
    logic        full;
    logic        pop;        // uart strobe.
    frame_byte_u pop_byte;   // fifo head.
    logic        empty;

    // tick, capture, byte sequence.
    frame_builder i_builder (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .digits    (digits),
        .full      (full),
        .push      (push),
        .push_byte (push_byte)
    );

    tx_byte_fifo i_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_byte (push_byte),
        .pop       (pop),
        .pop_byte  (pop_byte),
        .full      (full),
        .empty     (empty)
    );

    // 8n1 out.
    uart_tx i_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .pop_byte (pop_byte),
        .pop      (pop),
        .tx_pin   (tx_pin),
        .tx_busy  (tx_busy)
    );

endmodule

// File: hw/tx_byte_fifo.sv
`timescale 1ns/1ps

`include "nibble_uart_consts.svh"

module tx_byte_fifo (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  nibble_uart_pkg::frame_byte_u push_byte,
    input  logic                         pop,
    output nibble_uart_pkg::frame_byte_u pop_byte,
    output logic                         full,
    output logic                         empty
);

    import nibble_uart_pkg::*;

    localparam int PTR_W = $clog2(`NU_FIFO_DEPTH);

    frame_byte_u      mem [`NU_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // one extra bit for full.
    logic             do_push;
    logic             do_pop;

    // guard both sides against misuse.
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == (PTR_W+1)'(`NU_FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_byte = mem[rd_ptr];     // show-ahead head.

    ////////////////////////////////////////////////////////////
    // storage.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_byte;
    end

    ////////////////////////////////////////////////////////////
    // pointers and occupancy.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth.
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither.
            endcase
        end
    end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ps

`include "nibble_uart_consts.svh"

module uart_tx (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         empty,
    input  nibble_uart_pkg::frame_byte_u pop_byte,
    output logic                         pop,
    output logic                         tx_pin,
    output logic                         tx_busy
);

    localparam int CNT_W = $clog2(`NU_CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`NU_CLKS_PER_BIT - 1);
    localparam logic [3:0]       BIT_STOP = 4'd9;  // start, 8 data, stop.

    logic [CNT_W-1:0] bit_cnt;    // cycles into current bit.
    logic [3:0]       bit_idx;    // 0 start .. 9 stop.
    logic [9:0]       shift_q;
    logic             bit_end;
    logic             stop_end;

    assign bit_end  = (bit_cnt == CNT_LAST);
    assign stop_end = tx_busy && bit_end && (bit_idx == BIT_STOP);

    // pull next byte when idle, or at the very end of a stop bit.
    assign pop = !empty && (!tx_busy || stop_end);

    assign tx_pin = shift_q[0];   // lsb first.

    ////////////////////////////////////////////////////////////
    // serializer.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '1;            // line idles high.
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b0;
        end else if (pop) begin
            shift_q <= {1'b1, pop_byte.raw, 1'b0};  // stop, data, start.
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b1;
        end else if (tx_busy) begin
            if (bit_end) begin
                bit_cnt <= '0;
                if (bit_idx == BIT_STOP) begin
                    tx_busy <= 1'b0;   // last byte done with fifo dry.
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    shift_q <= {1'b1, shift_q[9:1]}; // back-fill ones.
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

// File: nibble_uart.f
+incdir+hw
hw/nibble_uart_pkg.sv
hw/frame_builder.sv
hw/tx_byte_fifo.sv
hw/uart_tx.sv
hw/nibble_uart_top.sv
testbench/nibble_uart_properties.sv
testbench/nibble_uart_tb.sv

// File: testbench/nibble_uart_properties.sv
`timescale 1ns/1ps

module nibble_uart_properties (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         push,
    input nibble_uart_pkg::frame_byte_u push_byte,
    input logic                         full,
    input logic                         pop,
    input logic                         empty,
    input logic                         tx_pin,
    input logic                         tx_busy
);

    int n_hold = 0;   // failures per rule.
    int n_pop  = 0;
    int n_idle = 0;
    int n_rst  = 0;
    int fail_cnt;     // read by the testbench.

    assign fail_cnt = n_hold + n_pop + n_idle + n_rst;

    ////////////////////////////////////////////////////////////
    // fifo strobes.
    ////////////////////////////////////////////////////////////

    // a push seen under full is not taken, so it must repeat unchanged.
    a_push_hold: assert property (@(posedge clk) disable iff (!rst_n)
        push && full |=> push && $stable(push_byte.raw))
        else begin n_hold++; $error("push taken or changed while fifo full"); end

    // a pop takes a real head entry and the start bit follows next cycle.
    a_pop_data: assert property (@(posedge clk) disable iff (!rst_n)
        pop |=> $past(!empty) && tx_busy && !tx_pin)
        else begin n_pop++; $error("pop while fifo empty or no start bit after pop"); end

    ////////////////////////////////////////////////////////////
    // serial line.
    ////////////////////////////////////////////////////////////

    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx_pin)
        else begin n_idle++; $error("tx_pin low while transmitter idle"); end

    a_rst_quiet: assert property (@(posedge clk) !rst_n |-> !tx_busy)
        else begin n_rst++; $error("tx_busy high during reset"); end

endmodule

bind nibble_uart_top nibble_uart_properties i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_byte (push_byte),
    .full      (full),
    .pop       (pop),
    .empty     (empty),
    .tx_pin    (tx_pin),
    .tx_busy   (tx_busy)
);

// File: testbench/nibble_uart_tb.sv
`timescale 1ns/1ps

`include "nibble_uart_consts.svh"

module nibble_uart_tb;

    import nibble_uart_pkg::*;

    localparam int NUM_RAND   = 4;                      // random frames.
    localparam int NUM_FRAMES = 1 + NUM_RAND + 2;       // fixed, random, resumed.
    localparam int LIMIT      = (NUM_FRAMES + 3) * `NU_FRAME_PERIOD;
    localparam int BIT_T      = `NU_CLKS_PER_BIT;
    localparam int DIG_W      = `NU_NUM_DIGITS * `NU_DIGIT_W;

    // digits 1..8 with d0 = 1. check byte worked out by hand.
    localparam logic [7:0] FIXED_FRAME [`NU_FRAME_BYTES] =
        '{8'h55, 8'hAA, 8'h87, 8'h65, 8'h43, 8'h21, 8'h80};

    typedef frame_byte_u [`NU_FRAME_BYTES-1:0] frame_bytes_t;

    logic             clk;
    logic             rst_n;
    logic             en;
    logic [DIG_W-1:0] digits;
    logic             tx_pin;
    logic             tx_busy;

    int          seed;
    int          cycle_cnt   = 0;   // cycles since reset release.
    int          frames_exp  = 0;
    int          frames_done = 0;
    int          value_errs  = 0;
    int          proto_errs  = 0;
    int          timeout_errs = 0;
    logic        quiet_chk;        // en low window.
    logic        quiet_seen  = 1'b0;
    frame_byte_u exp_q[$];
    frame_byte_u got_q[$];
    int          start_q[$];      // start-bit cycle per decoded byte.

    nibble_uart_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .digits  (digits),
        .tx_pin  (tx_pin),
        .tx_busy (tx_busy)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model.
    ////////////////////////////////////////////////////////////

    // sync, sync, digit pairs high digit first, xor of the pairs.
    function automatic frame_bytes_t ref_frame(input logic [DIG_W-1:0] d);
        frame_bytes_t f;
        int           p;
        f[0].raw = `NU_SYNC0;
        f[1].raw = `NU_SYNC1;
        for (p = 0; p < 4; p++) begin
            f[p+2].pair.hi = d[(7-2*p)*`NU_DIGIT_W +: `NU_DIGIT_W];
            f[p+2].pair.lo = d[(6-2*p)*`NU_DIGIT_W +: `NU_DIGIT_W];
        end
        f[6].raw = f[2].raw ^ f[3].raw ^ f[4].raw ^ f[5].raw;
        return f;
    endfunction

    task automatic queue_frame(input logic [DIG_W-1:0] d);
        frame_bytes_t f;
        int           k;
        f = ref_frame(d);
        for (k = 0; k < `NU_FRAME_BYTES; k++)
            exp_q.push_back(f[k]);
        frames_exp++;
    endtask

    // tick every period after release; builder is always idle by then.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= 0;
        end else begin
            if ((cycle_cnt % `NU_FRAME_PERIOD) == `NU_FRAME_PERIOD - 1 && en)
                queue_frame(digits);    // digits held at the tick.
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks.
    ////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input frame_byte_u got,
                              input frame_byte_u exp);
        if (got.raw !== exp.raw) begin
            value_errs++;
            $display("** Error: %s got 0x%02h expected 0x%02h", name, got.raw, exp.raw);
        end
    endtask

    task automatic check_gap(input int frame, input int pos, input int gap);
        if (gap != 10 * BIT_T) begin
            proto_errs++;
            $display("idle gap inside frame %0d: byte %0d started %0d cycles %s %0d",
                     frame, pos, gap, "after the last, not", 10 * BIT_T);
        end
    endtask

    function automatic int total_errs();
        return value_errs + proto_errs + timeout_errs + i_dut.i_props.fail_cnt;
    endfunction

    task automatic report_counts();
        $display("errors: value %0d, protocol %0d, assertion %0d, timeout %0d",
                 value_errs, proto_errs, i_dut.i_props.fail_cnt, timeout_errs);
    endtask

    // 8n1 decoder sampling each bit at its middle.
    initial begin : decode_serial
        frame_byte_u rx;
        int          b;
        int          t0;
        forever begin
            @(negedge clk);
            if (quiet_chk && !quiet_seen && (tx_busy !== 1'b0 || tx_pin !== 1'b1)) begin
                quiet_seen = 1'b1;
                proto_errs++;
                $display("line active at cycle %0d while en was low", cycle_cnt);
            end
            if (rst_n === 1'b1 && tx_pin === 1'b0) begin
                t0 = cycle_cnt;
                repeat (BIT_T / 2) @(negedge clk);
                if (tx_pin !== 1'b0) begin
                    proto_errs++;
                    $display("start bit at cycle %0d did not stay low", t0);
                end
                for (b = 0; b < 8; b++) begin
                    repeat (BIT_T) @(negedge clk);
                    rx.raw[b] = tx_pin;          // lsb first.
                end
                repeat (BIT_T) @(negedge clk);
                if (tx_pin !== 1'b1) begin
                    proto_errs++;
                    $display("stop bit low in byte starting at cycle %0d", t0);
                end
                got_q.push_back(rx);
                start_q.push_back(t0);
            end
        end
    end

    initial begin : compare_bytes
        frame_byte_u got;
        frame_byte_u exp;
        int          t0;
        int          t_prev;
        int          pos;
        pos    = 0;
        t_prev = 0;
        forever begin
            @(posedge clk);
            if (got_q.size() > 0) begin
                got = got_q.pop_front();
                t0  = start_q.pop_front();
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("byte 0x%02h decoded while no frame was due", got.raw);
                end else begin
                    exp = exp_q.pop_front();
                    check_byte($sformatf("tx_pin frame %0d byte %0d", frames_done, pos),
                               got, exp);
                end
                if (pos != 0)
                    check_gap(frames_done, pos, t0 - t_prev);
                t_prev = t0;
                if (pos == `NU_FRAME_BYTES - 1) begin
                    pos = 0;
                    frames_done++;
                end else begin
                    pos++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus.
    ////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_frames(input int n);
        while (frames_done < n)
            step();
    endtask

    initial begin : watchdog
        while (cycle_cnt < LIMIT)
            @(posedge clk);
        timeout_errs++;
        $display("timeout: run still going after %0d cycles", LIMIT);
        report_counts();
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        frame_bytes_t f;
        frame_byte_u  lit;
        int           i;
        clk       = 1'b0;
        rst_n     = 1'b0;
        en        = 1'b0;
        digits    = '0;
        quiet_chk = 1'b0;
        seed      = 83;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // fixed digits and the reference checked against hand values.
        en     = 1'b1;
        digits = 32'h8765_4321;
        f      = ref_frame(digits);
        for (i = 0; i < `NU_FRAME_BYTES; i++) begin
            lit.raw = FIXED_FRAME[i];
            check_byte($sformatf("ref_frame byte %0d", i), f[i], lit);
        end
        wait_frames(1);

        // random frames with digits changed before the payload is pushed.
        for (i = 0; i < NUM_RAND; i++) begin
            step();
            digits = $random(seed);
            while (tx_busy)
                step();
            while (!tx_busy)
                step();                          // next frame on the line.
            digits = $random(seed);              // payload bytes not yet pushed.
            wait_frames(2 + i);
        end

        // two silent periods before frames resume.
        while (tx_busy)
            step();
        en        = 1'b0;
        quiet_chk = 1'b1;
        repeat (2 * `NU_FRAME_PERIOD) step();
        quiet_chk = 1'b0;
        en        = 1'b1;
        wait_frames(NUM_FRAMES);

        step();
        if (exp_q.size() != 0 || frames_exp != frames_done) begin
            proto_errs++;
            $display("%0d frames due but %0d decoded", frames_exp, frames_done);
        end
        report_counts();
        if (total_errs() == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
